/* Bender.yml */
package:
  name: exec_datapath

sources:
  # packages first, modules after
  - rtl/cpu_types_pkg.sv
  - rtl/exec_pkg.sv
  - rtl/register_file.sv
  - rtl/alu.sv
  - rtl/instr_decoder.sv
  - rtl/exec_datapath.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/exec_datapath_tb.sv

/* exec_datapath.f */
rtl/cpu_types_pkg.sv
rtl/exec_pkg.sv
rtl/register_file.sv
rtl/alu.sv
rtl/instr_decoder.sv
rtl/exec_datapath.sv
sim/clock_gen.sv
sim/exec_datapath_tb.sv

/* rtl/alu.sv */
`timescale 1ns/10ps

module alu
  import cpu_types_pkg::*;
  import exec_pkg::*;
(
  input  alu_op_t alu_op,
  input  src_b_t  src_b,
  input  word_t   a,
  input  word_t   b_reg,
  input  word_t   imm,
  input  shamt_t  shamt,
  output word_t   result,
  output logic    zero,
  output logic    overflow
);

  // operand b after source select
  word_t b;
  // add and subtract kept apart for the overflow check
  word_t sum;
  word_t diff;

  assign b    = (src_b == SRC_IMM) ? imm : b_reg;
  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    result   = '0;
    overflow = 1'b0;
    case (alu_op)
      ALU_ADD: begin
        result = sum;
        // overflow when same-sign operands give a result of the other sign
        overflow = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
      end
      ALU_SUB: begin
        result = diff;
        // overflow when operand signs differ and the result sign leaves a
        overflow = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);
      end
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_NOR:  result = ~(a | b);
      ALU_SLT:  result = word_t'($signed(a) < $signed(b));
      ALU_SLTU: result = word_t'(a < b);
      // shifts act on b only
      ALU_SLL:  result = b << shamt;
      ALU_SRL:  result = b >> shamt;
      ALU_SRA:  result = word_t'($signed(b) >>> shamt);
      // low half of immediate into the upper half of the result
      ALU_LUI:  result = {imm[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
      default:  result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

/* rtl/cpu_types_pkg.sv */
package cpu_types_pkg;

  // architectural widths
  localparam int WORD_W  = 32;
  localparam int REG_W   = 5;
  localparam int OP_W    = 6;
  localparam int FUNCT_W = 6;
  localparam int SHAMT_W = 5;
  localparam int IMM_W   = 16;

  // basic data types
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [REG_W-1:0]   regbits_t;
  typedef logic [SHAMT_W-1:0] shamt_t;
  typedef logic [IMM_W-1:0]   imm16_t;

  // primary opcode, bits 31:26
  // only the implemented subset is listed, everything else is illegal
  typedef enum logic [OP_W-1:0] {
    RTYPE = 6'b000000,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    SLTIU = 6'b001011,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111
  } opcode_t;

  // funct field of r-type, bits 5:0
  typedef enum logic [FUNCT_W-1:0] {
    // shifts by shamt
    SLL  = 6'b000000,
    SRL  = 6'b000010,
    SRA  = 6'b000011,
    // arithmetic, no trap on overflow
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    // logic
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    // set on less than
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

endpackage

/* rtl/exec_datapath.sv */
`timescale 1ns/10ps

module exec_datapath
  import cpu_types_pkg::*;
  import exec_pkg::*;
(
  input  logic  CLK,
  input  logic  rst,
  input  logic  instr_valid,
  input  word_t instr,
  output word_t result,
  output logic  zero,
  output logic  overflow,
  output logic  illegal
);

  // decoder to register file
  regbits_t rsel1;
  regbits_t rsel2;
  regbits_t wsel;
  logic     wen;
  // decoder to alu
  word_t    imm;
  shamt_t   shamt;
  alu_op_t  alu_op;
  src_b_t   src_b;
  // register file to alu
  word_t    rdat1;
  word_t    rdat2;

  instr_decoder u_decoder (
    .instr_valid (instr_valid),
    .instr       (instr),
    .rsel1       (rsel1),
    .rsel2       (rsel2),
    .wsel        (wsel),
    .imm         (imm),
    .shamt       (shamt),
    .alu_op      (alu_op),
    .src_b       (src_b),
    .wen         (wen),
    .illegal     (illegal)
  );

  // alu result written back on the next edge
  register_file u_regfile (
    .CLK   (CLK),
    .rst   (rst),
    .wen   (wen),
    .wsel  (wsel),
    .wdat  (result),
    .rsel1 (rsel1),
    .rsel2 (rsel2),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  alu u_alu (
    .alu_op   (alu_op),
    .src_b    (src_b),
    .a        (rdat1),
    .b_reg    (rdat2),
    .imm      (imm),
    .shamt    (shamt),
    .result   (result),
    .zero     (zero),
    .overflow (overflow)
  );

endmodule

/* rtl/exec_pkg.sv */
package exec_pkg;

  // size of the register file
  localparam int NUM_REGS = 32;

  // operation the alu performs
  // decoupled from opcode/funct so several encodings can share one op
  typedef enum logic [3:0] {
    // add and subtract, also used by addiu
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    // bitwise logic
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_NOR  = 4'd5,
    // compares, result is 0 or 1
    ALU_SLT  = 4'd6,
    ALU_SLTU = 4'd7,
    // shifts of operand b by shamt
    ALU_SLL  = 4'd8,
    ALU_SRL  = 4'd9,
    ALU_SRA  = 4'd10,
    // immediate into upper half
    ALU_LUI  = 4'd11
  } alu_op_t;

  // where operand b comes from
  typedef enum logic {
    // second register read port
    SRC_REG = 1'b0,
    // extended immediate from decoder
    SRC_IMM = 1'b1
  } src_b_t;

endpackage

/* rtl/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder
  import cpu_types_pkg::*;
  import exec_pkg::*;
(
  input  logic     instr_valid,
  input  word_t    instr,
  // register selects
  output regbits_t rsel1,
  output regbits_t rsel2,
  output regbits_t wsel,
  // alu controls
  output word_t    imm,
  output shamt_t   shamt,
  output alu_op_t  alu_op,
  output src_b_t   src_b,
  // write-back and status
  output logic     wen,
  output logic     illegal
);

  // instruction fields
  opcode_t  opcode;
  funct_t   funct;
  regbits_t rs;
  regbits_t rt;
  regbits_t rd;
  imm16_t   imm16;

  // decode results
  logic legal;
  logic rtype;
  logic sign_ext;

  assign opcode = opcode_t'(instr[31:26]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign shamt  = instr[10:6];
  assign funct  = funct_t'(instr[5:0]);
  assign imm16  = instr[IMM_W-1:0];

  always_comb begin
    alu_op   = ALU_ADD;
    src_b    = SRC_REG;
    sign_ext = 1'b0;
    rtype    = 1'b0;
    legal    = 1'b1;
    case (opcode)
      RTYPE: begin
        rtype = 1'b1;
        case (funct)
          SLL:     alu_op = ALU_SLL;
          SRL:     alu_op = ALU_SRL;
          SRA:     alu_op = ALU_SRA;
          ADDU:    alu_op = ALU_ADD;
          SUBU:    alu_op = ALU_SUB;
          AND:     alu_op = ALU_AND;
          OR:      alu_op = ALU_OR;
          XOR:     alu_op = ALU_XOR;
          NOR:     alu_op = ALU_NOR;
          SLT:     alu_op = ALU_SLT;
          SLTU:    alu_op = ALU_SLTU;
          default: legal  = 1'b0;
        endcase
      end
      // sltiu compares unsigned after sign extension
      ADDIU: begin
        alu_op   = ALU_ADD;
        src_b    = SRC_IMM;
        sign_ext = 1'b1;
      end
      SLTI: begin
        alu_op   = ALU_SLT;
        src_b    = SRC_IMM;
        sign_ext = 1'b1;
      end
      SLTIU: begin
        alu_op   = ALU_SLTU;
        src_b    = SRC_IMM;
        sign_ext = 1'b1;
      end
      // logic immediates are zero extended
      ANDI: begin
        alu_op = ALU_AND;
        src_b  = SRC_IMM;
      end
      ORI: begin
        alu_op = ALU_OR;
        src_b  = SRC_IMM;
      end
      XORI: begin
        alu_op = ALU_XOR;
        src_b  = SRC_IMM;
      end
      LUI: begin
        alu_op = ALU_LUI;
        src_b  = SRC_IMM;
      end
      default: legal = 1'b0;
    endcase
  end

  // immediate extension
  assign imm = sign_ext ? {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16}
                        : {{(WORD_W-IMM_W){1'b0}}, imm16};

  // destination is rd for r-type and rt otherwise
  assign rsel1 = rs;
  assign rsel2 = rt;
  assign wsel  = rtype ? rd : rt;

  // both quiet while no instruction is presented
  assign wen     = instr_valid && legal;
  assign illegal = instr_valid && !legal;

endmodule

/* rtl/register_file.sv */
`timescale 1ns/10ps

module register_file
  import cpu_types_pkg::*;
  import exec_pkg::*;
(
  input  logic     CLK,
  input  logic     rst,
  // write port
  input  logic     wen,
  input  regbits_t wsel,
  input  word_t    wdat,
  // read ports
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  output word_t    rdat1,
  output word_t    rdat2
);

  // storage
  // entry 0 is cleared by reset and never written
  word_t regs [NUM_REGS];

  // write on rising edge
  always_ff @(posedge CLK) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (wen && (wsel != '0)) begin
      regs[wsel] <= wdat;
    end
  end

  // combinational reads
  // a same-cycle write is not bypassed so the old value comes out
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

  // $0 reads as zero on port 1
  rsel1_zero_reads_zero: assert property (
    @(posedge CLK) disable iff (rst)
    (rsel1 == '0) |-> (rdat1 == '0)
  ) else $error("register_file: rdat1 nonzero for rsel1 = 0");

  // decoder must keep the write strobe quiet while reset is held
  no_write_in_reset: assert property (
    @(posedge CLK)
    rst |-> !wen
  ) else $error("register_file: wen high during rst");

  // a write lands and is visible on the next cycle's read
  write_then_read: assert property (
    @(posedge CLK) disable iff (rst)
    (wen && (wsel != '0) && (rsel2 == wsel)) ##1 (rsel2 == $past(wsel))
      |-> (rdat2 == $past(wdat, 1))
  ) else $error("register_file: written value not read back on port 2");

endmodule

/* sim/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic CLK
);

  // free-running clock, starts low
  initial begin
    CLK = 1'b0;
    forever begin
      // half period per phase
      #(PERIOD_NS / 2);
      CLK = ~CLK;
    end
  end

endmodule

/* sim/exec_datapath_tb.sv */
`timescale 1ns/10ps

module exec_datapath_tb
  import cpu_types_pkg::*;
  import exec_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int CHECK_OFFSET = CLK_PERIOD - 10;
  localparam int RESET_CYCLES = 16;
  localparam int SEED         = 19;
  // test lengths
  localparam int N_RAND_R  = 200;
  localparam int N_ITYPE   = 8;
  localparam int N_ILLEGAL = 8;
  localparam int N_INVALID = 8;
  // clear, write/read, preload, overflow, random, i-type, $0, illegal, invalid
  localparam int TOTAL_INSTR = 32 + 64 + 62 + 6 + N_RAND_R + 7 * N_ITYPE * 2 + 2
                               + 2 * N_ILLEGAL + 2 * N_INVALID;
  localparam int EXPECTED_VALID_CHECKS = TOTAL_INSTR - N_INVALID;
  localparam int MARGIN_CYCLES = 50;
  localparam int TIMEOUT_NS = (TOTAL_INSTR + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  // expected outputs for one instruction
  typedef struct packed {
    word_t result;
    logic  zero;
    logic  overflow;
    logic  illegal;
    logic  legal;
  } expect_t;

  logic  CLK;
  logic  rst;
  logic  instr_valid;
  word_t instr;
  word_t result;
  logic  zero;
  logic  overflow;
  logic  illegal;

  // compare enable, raised when reset drops
  logic  checking;
  int    valid_checks = 0;
  // architectural state as the model sees it
  word_t model_regs [NUM_REGS] = '{default: '0};

  clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clock (.CLK(CLK));

  exec_datapath DUT (
    .CLK         (CLK),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .result      (result),
    .zero        (zero),
    .overflow    (overflow),
    .illegal     (illegal)
  );

  // instruction builders
  function automatic word_t encode_rtype(input logic [5:0] fn, input regbits_t rs,
                                         input regbits_t rt, input regbits_t rd,
                                         input shamt_t sh);
    return {6'b000000, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t encode_itype(input logic [5:0] op, input regbits_t rs,
                                         input regbits_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [5:0] funct_by_index(input int idx);
    case (idx)
      0:       return SLL;
      1:       return SRL;
      2:       return SRA;
      3:       return ADDU;
      4:       return SUBU;
      5:       return AND;
      6:       return OR;
      7:       return XOR;
      8:       return NOR;
      9:       return SLT;
      default: return SLTU;
    endcase
  endfunction

  function automatic logic [5:0] itype_by_index(input int idx);
    case (idx)
      0:       return ADDIU;
      1:       return SLTI;
      2:       return SLTIU;
      3:       return ANDI;
      4:       return ORI;
      5:       return XORI;
      default: return LUI;
    endcase
  endfunction

  // reference model, straight from the isa rules
  function automatic expect_t model_exec(input word_t ins, input logic valid,
                                         ref word_t regs [NUM_REGS]);
    expect_t     e;
    regbits_t    rs;
    regbits_t    rt;
    regbits_t    rd;
    regbits_t    dest;
    shamt_t      sh;
    word_t       va;
    word_t       vb;
    word_t       sx;
    word_t       zx;
    logic [32:0] wide;
    rs = ins[25:21];
    rt = ins[20:16];
    rd = ins[15:11];
    sh = ins[10:6];
    va = (rs == '0) ? '0 : regs[rs];
    vb = (rt == '0) ? '0 : regs[rt];
    sx = {{16{ins[15]}}, ins[15:0]};
    zx = {16'h0000, ins[15:0]};
    e = '0;
    e.legal = 1'b1;
    dest = rt;
    case (ins[31:26])
      6'h00: begin
        dest = rd;
        case (ins[5:0])
          6'h00: e.result = vb << sh;
          6'h02: e.result = vb >> sh;
          // logical shift, then fill the vacated top bits with the sign
          6'h03: e.result = (vb >> sh) | (vb[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
          6'h21: begin
            wide = {va[31], va} + {vb[31], vb};
            e.result   = wide[31:0];
            e.overflow = wide[32] ^ wide[31];
          end
          6'h23: begin
            wide = {va[31], va} - {vb[31], vb};
            e.result   = wide[31:0];
            e.overflow = wide[32] ^ wide[31];
          end
          6'h24: e.result = va & vb;
          6'h25: e.result = va | vb;
          6'h26: e.result = va ^ vb;
          6'h27: e.result = ~(va | vb);
          6'h2a: e.result = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
          6'h2b: e.result = (va < vb) ? 32'd1 : 32'd0;
          default: e.legal = 1'b0;
        endcase
      end
      6'h09: begin
        wide = {va[31], va} + {sx[31], sx};
        e.result   = wide[31:0];
        e.overflow = wide[32] ^ wide[31];
      end
      6'h0a: e.result = ($signed(va) < $signed(sx)) ? 32'd1 : 32'd0;
      // sign-extended immediate, unsigned compare
      6'h0b: e.result = (va < sx) ? 32'd1 : 32'd0;
      6'h0c: e.result = va & zx;
      6'h0d: e.result = va | zx;
      6'h0e: e.result = va ^ zx;
      6'h0f: e.result = {ins[15:0], 16'h0000};
      default: e.legal = 1'b0;
    endcase
    e.zero    = (e.result == '0);
    e.illegal = valid && !e.legal;
    // write-back, $0 stays zero
    if (valid && e.legal && (dest != '0)) begin
      regs[dest] = e.result;
    end
    return e;
  endfunction

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("error: time %0t, signal %s, expected %h, actual %h",
               $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "output mismatch on %s", name);
    end
  endtask

  // present one instruction for one cycle
  task automatic issue(input word_t ins, input logic valid);
    @(posedge CLK);
    instr       <= ins;
    instr_valid <= valid;
  endtask

  // addu $0, $k, $0 shows register k on result
  task automatic read_reg(input regbits_t k);
    issue(encode_rtype(ADDU, k, 5'd0, 5'd0, 5'd0), 1'b1);
  endtask

  // sample late in the cycle, outputs settled
  initial begin : compare_outputs
    expect_t want;
    forever begin
      @(posedge CLK);
      #(CHECK_OFFSET);
      if (checking) begin
        want = model_exec(instr, instr_valid, model_regs);
        check_value("illegal", word_t'(want.illegal), word_t'(illegal));
        // result of an illegal encoding is undefined
        if (want.legal) begin
          check_value("result", want.result, result);
          check_value("zero", word_t'(want.zero), word_t'(zero));
          check_value("overflow", word_t'(want.overflow), word_t'(overflow));
        end
        if (instr_valid) begin
          valid_checks++;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: run still going after %0d ns", TIMEOUT_NS);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    word_t       ins;
    regbits_t    rs;
    regbits_t    rt;
    regbits_t    rd;
    regbits_t    target;
    logic [15:0] imm;
    void'($urandom(SEED));
    rst         <= 1'b1;
    instr_valid <= 1'b0;
    instr       <= '0;
    checking    <= 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst      <= 1'b0;
    checking <= 1'b1;

    // all registers zero after reset
    for (int k = 0; k < NUM_REGS; k++) begin
      issue(encode_rtype(OR, regbits_t'(k), 5'd0, 5'd0, 5'd0), 1'b1);
    end
    // write 100+k everywhere, then read back
    for (int k = 0; k < NUM_REGS; k++) begin
      issue(encode_itype(ORI, 5'd0, regbits_t'(k), 16'(100 + k)), 1'b1);
    end
    for (int k = 0; k < NUM_REGS; k++) begin
      read_reg(regbits_t'(k));
    end

    // random contents for the r-type run
    for (int k = 1; k < NUM_REGS; k++) begin
      issue(encode_itype(LUI, 5'd0, regbits_t'(k), 16'($urandom)), 1'b1);
      issue(encode_itype(ORI, regbits_t'(k), regbits_t'(k), 16'($urandom)), 1'b1);
    end
    // max positive plus one, min negative minus one
    issue(encode_itype(LUI, 5'd0, 5'd1, 16'h7fff), 1'b1);
    issue(encode_itype(ORI, 5'd1, 5'd1, 16'hffff), 1'b1);
    issue(encode_itype(ADDIU, 5'd0, 5'd2, 16'h0001), 1'b1);
    issue(encode_rtype(ADDU, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1);
    issue(encode_itype(LUI, 5'd0, 5'd4, 16'h8000), 1'b1);
    issue(encode_rtype(SUBU, 5'd4, 5'd2, 5'd5, 5'd0), 1'b1);
    for (int n = 0; n < N_RAND_R; n++) begin
      rs  = regbits_t'($urandom_range(31, 0));
      rt  = regbits_t'($urandom_range(31, 0));
      rd  = regbits_t'($urandom_range(31, 0));
      ins = encode_rtype(funct_by_index($urandom_range(10, 0)), rs, rt, rd,
                         shamt_t'($urandom_range(31, 0)));
      issue(ins, 1'b1);
    end

    // immediates with bit 15 set, then read rt back
    for (int op = 0; op < 7; op++) begin
      for (int n = 0; n < N_ITYPE; n++) begin
        rs  = regbits_t'($urandom_range(31, 0));
        rt  = regbits_t'($urandom_range(31, 1));
        imm = 16'($urandom) | 16'h8000;
        issue(encode_itype(itype_by_index(op), rs, rt, imm), 1'b1);
        read_reg(rt);
      end
    end

    // $0 ignores writes
    issue(encode_itype(ADDIU, 5'd0, 5'd0, 16'd5), 1'b1);
    read_reg(5'd0);

    // illegal opcodes and functs, target keeps its value
    for (int n = 0; n < N_ILLEGAL; n++) begin
      rs     = regbits_t'($urandom_range(31, 0));
      rt     = regbits_t'($urandom_range(31, 0));
      target = regbits_t'($urandom_range(31, 1));
      case (n % 4)
        // lw, sw: unsupported opcodes
        0: ins = encode_itype(6'h23, rs, target, 16'($urandom));
        1: ins = encode_itype(6'h2b, rs, target, 16'($urandom));
        // add with trap, jr: unsupported functs
        2: ins = encode_rtype(6'h20, rs, rt, target, 5'd0);
        default: ins = encode_rtype(6'h08, rs, rt, target, 5'd0);
      endcase
      issue(ins, 1'b1);
      read_reg(target);
    end
    // legal ori with valid low must not write
    for (int n = 0; n < N_INVALID; n++) begin
      target = regbits_t'($urandom_range(31, 1));
      issue(encode_itype(ORI, 5'd0, target, 16'($urandom)), 1'b0);
      read_reg(target);
    end

    issue('0, 1'b0);
    @(posedge CLK);
    if (valid_checks == EXPECTED_VALID_CHECKS) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("compare process ran %0d checks, %0d were due",
               valid_checks, EXPECTED_VALID_CHECKS);
      $display("TEST FAIL");
      $fatal(1, "check count mismatch");
    end
  end

endmodule
